//--- compile.f
+incdir+tests
verilog/list_sel_pkg.sv
verilog/list_sel_rf.sv
verilog/list_sel_pick.sv
verilog/list_sel_mem.sv
tests/list_sel_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the list selection testbench with Verilator and runs it

ROOT_DIR=$(cd "$(dirname "$0")" && pwd)
cd "$ROOT_DIR" || exit 1

LOG_FILE=sim.log
OBJ_DIR=obj_dir
SIM_BIN=list_sel_sim

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f \
    --top-module list_sel_tb \
    -Mdir "$OBJ_DIR" \
    -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$OBJ_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$LOG_FILE"; then
    echo "Simulation result: passed"
    exit 0
else
    echo "Simulation result: failed"
    exit 1
fi

//--- tests/list_sel_ref.svh
`ifndef LIST_SEL_REF_SVH
`define LIST_SEL_REF_SVH

// ------------------------------
// Shadow register files
// ------------------------------

// Mirrors of both lists, updated at the moment a write is driven
list_sel_pkg::ldb_entry_t ldb_shadow [DEPTH];
list_sel_pkg::dir_entry_t dir_shadow [DEPTH];

int error_count = 0;
int check_count = 0;

// Expected selection for one queue, built from the shadow contents
// An entry counts only with vld set and a nonzero count
// The load-balanced entry keeps ties, so it loses only to a strictly higher pri
function automatic list_sel_pkg::sel_result_t ref_select(input logic [AW-1:0] qid);
    list_sel_pkg::ldb_entry_t  l;
    list_sel_pkg::dir_entry_t  d;
    logic                      l_ok;
    logic                      d_ok;
    list_sel_pkg::sel_result_t r;
    l    = ldb_shadow[qid];
    d    = dir_shadow[qid];
    l_ok = (l.vld == 1'b1) && (l.count != 11'd0);
    d_ok = (d.vld == 1'b1) && (d.count != 11'd0);
    r     = '0;
    r.qid = list_sel_pkg::LS_QID_W'(qid);
    if (l_ok && (!d_ok || (l.pri >= d.pri))) begin
        r.src   = list_sel_pkg::SRC_LDB;
        r.pri   = l.pri;
        r.count = l.count;
        r.tag   = l.tag;
    end else if (d_ok) begin
        r.src   = list_sel_pkg::SRC_DIR;
        r.pri   = d.pri;
        r.count = d.count;
        // Seven zero bits on top of the 25-bit directed tag
        r.tag   = {7'b0, d.tag};
    end
    return r;
endfunction

// Compares one value and reports a mismatch on the spot
task automatic check_value(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
    check_count++;
    if (expected !== actual) begin
        error_count++;
        $display("Fail %s: expected 0x%0h actual 0x%0h", name, expected, actual);
    end
endtask

`endif

//--- tests/list_sel_tb.sv
`timescale 1ns/1ps

module list_sel_tb;

    localparam int DEPTH           = list_sel_pkg::LS_DEPTH;
    localparam int AW              = $clog2(DEPTH);
    // Upper bound on requests over all tests, the random test dominates
    localparam int MAX_REQ         = 320;
    localparam int WATCHDOG_CYCLES = MAX_REQ * 40 + 200;

    logic                      clk;
    logic                      rst_n;
    logic                      ldb_we;
    logic [AW-1:0]             ldb_waddr;
    list_sel_pkg::ldb_entry_t  ldb_wdata;
    logic                      dir_we;
    logic [AW-1:0]             dir_waddr;
    list_sel_pkg::dir_entry_t  dir_wdata;
    logic                      sel_req;
    logic [AW-1:0]             sel_qid;
    logic                      sel_valid;
    list_sel_pkg::sel_result_t sel_result;

    // Expected results in request order, popped by the compare process
    list_sel_pkg::sel_result_t exp_q [$];
    list_sel_pkg::sel_result_t exp_res;
    string                     cur_test;
    int                        test_start_errors;
    integer                    seed = 3927;

    `include "list_sel_ref.svh"

    list_sel_mem #(.DEPTH(DEPTH)) list_sel_mem_inst (
         .clk        (clk)
        ,.rst_n      (rst_n)
        ,.ldb_we     (ldb_we)
        ,.ldb_waddr  (ldb_waddr)
        ,.ldb_wdata  (ldb_wdata)
        ,.dir_we     (dir_we)
        ,.dir_waddr  (dir_waddr)
        ,.dir_wdata  (dir_wdata)
        ,.sel_req    (sel_req)
        ,.sel_qid    (sel_qid)
        ,.sel_valid  (sel_valid)
        ,.sel_result (sel_result)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------

    // One falling edge of stimulus; the expected result is taken before this
    // cycle's writes reach the shadows, matching the old-data read rule
    task automatic drive_cycle(input logic lwe, input logic [AW-1:0] lwa,
                               input list_sel_pkg::ldb_entry_t lwd,
                               input logic dwe, input logic [AW-1:0] dwa,
                               input list_sel_pkg::dir_entry_t dwd,
                               input logic req, input logic [AW-1:0] qid);
        @(negedge clk);
        ldb_we    = lwe;
        ldb_waddr = lwa;
        ldb_wdata = lwd;
        dir_we    = dwe;
        dir_waddr = dwa;
        dir_wdata = dwd;
        sel_req   = req;
        sel_qid   = qid;
        if (req) exp_q.push_back(ref_select(qid));
        if (lwe) ldb_shadow[lwa] = lwd;
        if (dwe) dir_shadow[dwa] = dwd;
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, '0, 1'b0, '0, '0, 1'b0, '0);
    endtask

    task automatic request_queue(input int q);
        drive_cycle(1'b0, '0, '0, 1'b0, '0, '0, 1'b1, AW'(q));
    endtask

    task automatic write_both(input int q, input list_sel_pkg::ldb_entry_t l,
                              input list_sel_pkg::dir_entry_t d);
        drive_cycle(1'b1, AW'(q), l, 1'b1, AW'(q), d, 1'b0, '0);
    endtask

    // Idles until every outstanding request has come back
    task automatic drain_results();
        while (exp_q.size() != 0) idle_cycle();
        idle_cycle();
    endtask

    function automatic list_sel_pkg::ldb_entry_t rand_ldb();
        list_sel_pkg::ldb_entry_t e;
        logic [31:0]              r;
        r        = $random(seed);
        e.vld    = (r[1:0] != 2'b00);
        e.pri    = r[4:2];
        // Roughly one entry in four has an empty count
        e.count  = (r[6:5] == 2'b00) ? 11'd0 : r[17:7];
        e.weight = r[25:18];
        e.tag    = $random(seed);
        return e;
    endfunction

    function automatic list_sel_pkg::dir_entry_t rand_dir();
        list_sel_pkg::dir_entry_t e;
        logic [31:0]              r;
        logic [31:0]              t;
        r       = $random(seed);
        t       = $random(seed);
        e.vld   = (r[1:0] != 2'b00);
        e.pri   = r[4:2];
        e.count = (r[6:5] == 2'b00) ? 11'd0 : r[17:7];
        e.tag   = t[24:0];
        return e;
    endfunction

    task automatic start_test(input string name);
        cur_test          = name;
        test_start_errors = error_count;
    endtask

    task automatic report_test();
        $display("Test %s finished with %0d errors", cur_test,
                 error_count - test_start_errors);
    endtask

    // ------------------------------
    // Compare process
    // ------------------------------

    // Outputs settle after the rising edge, so they are read at the falling one
    always @(negedge clk) begin
        if (rst_n && sel_valid) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("Error in %s: a result came out with no request pending", cur_test);
            end else begin
                exp_res = exp_q.pop_front();
                check_value({cur_test, " result"}, 64'(exp_res), 64'(sel_result));
            end
        end
    end

    // ------------------------------
    // Tests
    // ------------------------------

    task automatic run_reset_idle();
        list_sel_pkg::ldb_entry_t l;
        list_sel_pkg::dir_entry_t d;
        start_test("reset_idle");
        repeat (6) begin
            idle_cycle();
            check_value("reset_idle sel_valid", 64'd0, 64'(sel_valid));
        end
        // Every queue starts with invalid entries in both lists
        for (int q = 0; q < DEPTH; q++) begin
            l     = rand_ldb();
            l.vld = 1'b0;
            d     = rand_dir();
            d.vld = 1'b0;
            write_both(q, l, d);
            check_value("reset_idle sel_valid", 64'd0, 64'(sel_valid));
        end
        request_queue(5);
        drain_results();
        report_test();
    endtask

    task automatic run_ldb_only();
        list_sel_pkg::ldb_entry_t l;
        list_sel_pkg::dir_entry_t d;
        start_test("ldb_only");
        l = '{vld: 1'b1, pri: 3'd3, count: 11'd7, tag: 32'h8000_1234, weight: 8'h5a};
        d = '{vld: 1'b1, pri: 3'd7, count: 11'd0, tag: 25'h1ab_cdef};
        write_both(0, l, d);
        request_queue(0);
        // The pulse belongs to the second edge after the request, and only to it
        idle_cycle();
        check_value("ldb_only valid after one edge", 64'd0, 64'(sel_valid));
        idle_cycle();
        check_value("ldb_only valid after two edges", 64'd1, 64'(sel_valid));
        idle_cycle();
        check_value("ldb_only valid after three edges", 64'd0, 64'(sel_valid));
        drain_results();
        report_test();
    endtask

    task automatic run_priority();
        start_test("priority");
        write_both(1, '{1'b1, 3'd2, 11'd4, 32'h1111_0001, 8'h01},
                   '{1'b1, 3'd5, 11'd9, 25'h1f0_f0f0});
        write_both(2, '{1'b1, 3'd6, 11'd1, 32'h2222_0002, 8'h02},
                   '{1'b1, 3'd3, 11'd2, 25'h0aa_aaaa});
        write_both(3, '{1'b1, 3'd4, 11'd3, 32'h3333_0003, 8'h03},
                   '{1'b1, 3'd4, 11'd5, 25'h155_5555});
        request_queue(1);
        request_queue(2);
        request_queue(3);
        drain_results();
        report_test();
    endtask

    task automatic run_back_to_back();
        list_sel_pkg::ldb_entry_t l;
        list_sel_pkg::dir_entry_t d;
        start_test("back_to_back");
        for (int q = 0; q < DEPTH; q++) begin
            l       = rand_ldb();
            l.vld   = 1'b1;
            l.count = l.count | 11'd1;
            d       = rand_dir();
            d.vld   = 1'b1;
            d.count = d.count | 11'd1;
            write_both(q, l, d);
        end
        // Results trail the requests by two cycles with no gap between them
        for (int q = 0; q < DEPTH; q++) begin
            request_queue(q);
            if (q >= 2) check_value("back_to_back pulse", 64'd1, 64'(sel_valid));
        end
        repeat (2) begin
            idle_cycle();
            check_value("back_to_back pulse", 64'd1, 64'(sel_valid));
        end
        idle_cycle();
        check_value("back_to_back end", 64'd0, 64'(sel_valid));
        drain_results();
        report_test();
    endtask

    task automatic run_random();
        logic [31:0]   r;
        logic [AW-1:0] lwa;
        logic [AW-1:0] dwa;
        start_test("random");
        repeat (300) begin
            r   = $random(seed);
            lwa = r[9:7];
            dwa = r[12:10];
            // A write never shares its edge and address with a read
            if (r[2] && r[0] && (lwa == r[6:4])) lwa = lwa + 1'b1;
            if (r[2] && r[1] && (dwa == r[6:4])) dwa = dwa + 1'b1;
            drive_cycle(r[0], lwa, rand_ldb(), r[1], dwa, rand_dir(), r[2], r[6:4]);
        end
        drain_results();
        report_test();
    endtask

    // ------------------------------
    // Main sequence and watchdog
    // ------------------------------

    initial begin
        rst_n     = 1'b0;
        ldb_we    = 1'b0;
        ldb_waddr = '0;
        ldb_wdata = '0;
        dir_we    = 1'b0;
        dir_waddr = '0;
        dir_wdata = '0;
        sel_req   = 1'b0;
        sel_qid   = '0;
        cur_test  = "reset";
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        run_reset_idle();
        run_ldb_only();
        run_priority();
        run_back_to_back();
        run_random();
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Error: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- verilog/list_sel_mem.sv
`timescale 1ns/1ps

// List selection top level
// Two register files are read side by side and a picker merges the entries
module list_sel_mem #(
     parameter int DEPTH = list_sel_pkg::LS_DEPTH
) (
     input  logic                        clk
    ,input  logic                        rst_n

    // Load-balanced list write port
    ,input  logic                        ldb_we
    ,input  logic [$clog2(DEPTH)-1:0]    ldb_waddr
    ,input  list_sel_pkg::ldb_entry_t    ldb_wdata

    // Directed list write port
    ,input  logic                        dir_we
    ,input  logic [$clog2(DEPTH)-1:0]    dir_waddr
    ,input  list_sel_pkg::dir_entry_t    dir_wdata

    // Schedule request and its result
    ,input  logic                        sel_req
    ,input  logic [$clog2(DEPTH)-1:0]    sel_qid
    ,output logic                        sel_valid
    ,output list_sel_pkg::sel_result_t   sel_result
);

    // Entries read for the requested queue, valid the cycle after the request
    list_sel_pkg::ldb_entry_t ldb_rdata;
    list_sel_pkg::dir_entry_t dir_rdata;

    // ------------------------------
    // Register files
    // ------------------------------

    // One clock drives both ports of each register file
    list_sel_rf #(
         .DEPTH     (DEPTH)
        ,.entry_t   (list_sel_pkg::ldb_entry_t)
    ) u_ldb_rf (
         .wclk      (clk)
        ,.rst_n     (rst_n)
        ,.we        (ldb_we)
        ,.waddr     (ldb_waddr)
        ,.wdata     (ldb_wdata)
        ,.rclk      (clk)
        ,.re        (sel_req)
        ,.raddr     (sel_qid)
        ,.rdata     (ldb_rdata)
    );

    list_sel_rf #(
         .DEPTH     (DEPTH)
        ,.entry_t   (list_sel_pkg::dir_entry_t)
    ) u_dir_rf (
         .wclk      (clk)
        ,.rst_n     (rst_n)
        ,.we        (dir_we)
        ,.waddr     (dir_waddr)
        ,.wdata     (dir_wdata)
        ,.rclk      (clk)
        ,.re        (sel_req)
        ,.raddr     (sel_qid)
        ,.rdata     (dir_rdata)
    );

    // ------------------------------
    // Picker
    // ------------------------------

    list_sel_pick #(
         .DEPTH      (DEPTH)
    ) u_pick (
         .clk        (clk)
        ,.rst_n      (rst_n)
        ,.sel_req    (sel_req)
        ,.sel_qid    (sel_qid)
        ,.ldb_rdata  (ldb_rdata)
        ,.dir_rdata  (dir_rdata)
        ,.sel_valid  (sel_valid)
        ,.sel_result (sel_result)
    );

endmodule

//--- verilog/list_sel_pick.sv
`timescale 1ns/1ps

// Picks one winner between the load-balanced and directed entries of a queue
// The entries come straight from the register files one cycle after the request
module list_sel_pick #(
     parameter int DEPTH = 8
) (
     input  logic                        clk
    ,input  logic                        rst_n

    ,input  logic                        sel_req
    ,input  logic [$clog2(DEPTH)-1:0]    sel_qid

    ,input  list_sel_pkg::ldb_entry_t    ldb_rdata
    ,input  list_sel_pkg::dir_entry_t    dir_rdata

    ,output logic                        sel_valid
    ,output list_sel_pkg::sel_result_t   sel_result
);

    // ------------------------------
    // Request alignment stage
    // ------------------------------

    // Request strobe and queue id delayed to line up with the read data
    logic                     req_q;
    logic [$clog2(DEPTH)-1:0] qid_q;

    // Eligibility of each list entry for the queue being selected
    logic ldb_elig;
    logic dir_elig;

    // Winning list and the result built from it, before the output register
    list_sel_pkg::src_t        pick_src;
    list_sel_pkg::sel_result_t pick_res;

    // The delayed request strobe clears on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else begin
            req_q <= sel_req;
        end
    end

    always_ff @(posedge clk) begin
        qid_q <= sel_qid;
    end

    // ------------------------------
    // Selection rule
    // ------------------------------

    // An entry takes part only when it is valid and still has work queued
    assign ldb_elig = ldb_rdata.vld && (ldb_rdata.count != '0);
    assign dir_elig = dir_rdata.vld && (dir_rdata.count != '0);

    // Higher pri wins when both lists are eligible
    // On a pri tie the load-balanced list is preferred
    always_comb begin
        pick_src = list_sel_pkg::SRC_NONE;
        if (ldb_elig && dir_elig) begin
            if (dir_rdata.pri > ldb_rdata.pri) begin
                pick_src = list_sel_pkg::SRC_DIR;
            end else begin
                pick_src = list_sel_pkg::SRC_LDB;
            end
        end else if (ldb_elig) begin
            pick_src = list_sel_pkg::SRC_LDB;
        end else if (dir_elig) begin
            pick_src = list_sel_pkg::SRC_DIR;
        end
    end

    // ------------------------------
    // Result assembly
    // ------------------------------

    // Fields start at zero so a SRC_NONE result carries no pri, count or tag
    always_comb begin
        pick_res       = '0;
        pick_res.src   = pick_src;
        pick_res.qid   = list_sel_pkg::LS_QID_W'(qid_q);
        case (pick_src)
            list_sel_pkg::SRC_LDB: begin
                pick_res.pri   = ldb_rdata.pri;
                pick_res.count = ldb_rdata.count;
                pick_res.tag   = ldb_rdata.tag;
            end
            list_sel_pkg::SRC_DIR: begin
                pick_res.pri   = dir_rdata.pri;
                pick_res.count = dir_rdata.count;
                // The 25-bit directed tag is zero-extended into the upper tag bits
                pick_res.tag   = 32'(dir_rdata.tag);
            end
            default: begin
            end
        endcase
    end

    // ------------------------------
    // Output register
    // ------------------------------

    // sel_valid is a one-cycle pulse with no back-pressure
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_valid <= 1'b0;
        end else begin
            sel_valid <= req_q;
        end
    end

    // Result only loads on a live request so it holds between pulses
    always_ff @(posedge clk) begin
        if (req_q) begin
            sel_result <= pick_res;
        end
    end

    // ------------------------------
    // Assertions
    // ------------------------------

    // Neither entry eligible must come out one edge later as an empty result
    assert property (
        @(posedge clk) disable iff (!rst_n)
        (req_q && !ldb_elig && !dir_elig) |=>
            (sel_valid && (sel_result.src == list_sel_pkg::SRC_NONE)
                       && (sel_result.count == '0))
    ) else $error("list_sel_pick: empty selection without zero count");

    // Any winner reported on the output must carry work
    assert property (
        @(posedge clk) disable iff (!rst_n)
        (sel_valid && (sel_result.src != list_sel_pkg::SRC_NONE)) |->
            (sel_result.count != '0)
    ) else $error("list_sel_pick: winning result with zero count");

endmodule

//--- verilog/list_sel_pkg.sv
package list_sel_pkg;

    // ------------------------------
    // Sizing
    // ------------------------------

    // Number of queues served by the list selection subsystem
    parameter int LS_DEPTH = 8;

    // Width of the queue id carried in a selection result
    parameter int LS_QID_W = 3;

    // ------------------------------
    // List entries
    // ------------------------------

    // Load-balanced list entry, 55 bits wide to match the 8x55 register file
    // A higher pri value wins arbitration
    // The weight field is kept in the entry but takes no part in selection
    typedef struct packed {
        logic        vld;
        logic [2:0]  pri;
        logic [10:0] count;
        logic [31:0] tag;
        logic [7:0]  weight;
    } ldb_entry_t;

    // Directed list entry, 40 bits wide
    // Its tag is narrower than the load-balanced one
    typedef struct packed {
        logic        vld;
        logic [2:0]  pri;
        logic [10:0] count;
        logic [24:0] tag;
    } dir_entry_t;

    // ------------------------------
    // Selection result
    // ------------------------------

    // Which list won the selection for a queue
    typedef enum logic [1:0] {
        SRC_NONE = 2'd0,
        SRC_LDB  = 2'd1,
        SRC_DIR  = 2'd2
    } src_t;

    // Selection result, 51 bits wide
    // A directed tag is zero-extended into the 32-bit tag field
    // With src at SRC_NONE the pri, count and tag fields are all zero
    typedef struct packed {
        src_t                src;
        logic [LS_QID_W-1:0] qid;
        logic [2:0]          pri;
        logic [10:0]         count;
        logic [31:0]         tag;
    } sel_result_t;

endpackage

//--- verilog/list_sel_rf.sv
`timescale 1ns/1ps

// Two-port register file holding one entry per queue
// The same module stores both list types through the entry_t type parameter
module list_sel_rf #(
     parameter int  DEPTH   = 8
    ,parameter type entry_t = logic [54:0]
) (
     input  logic                     wclk
    ,input  logic                     rst_n
    ,input  logic                     we
    ,input  logic [$clog2(DEPTH)-1:0] waddr
    ,input  entry_t                   wdata

    ,input  logic                     rclk
    ,input  logic                     re
    ,input  logic [$clog2(DEPTH)-1:0] raddr

    ,output entry_t                   rdata
);

    // ------------------------------
    // Storage
    // ------------------------------

    // Array contents survive reset and only the read data register clears
    entry_t mem [DEPTH];

    // Read-side reset after the two-flop synchronizer
    logic [1:0] rd_rst_sync;
    logic       rd_rst_n;

    // ------------------------------
    // Read-side reset synchronizer
    // ------------------------------

    // The external reset is retimed into the rclk domain through two flops
    // The read data register therefore leaves reset two rclk edges after rst_n rises
    // Reads issued before that point still return zero
    always_ff @(posedge rclk) begin
        rd_rst_sync <= {rd_rst_sync[0], rst_n};
    end

    assign rd_rst_n = rd_rst_sync[1];

    // ------------------------------
    // Write port
    // ------------------------------

    // A write strobe seen at a rising wclk edge stores wdata at that edge
    // There is no handshake and the caller owns the strobe timing
    always_ff @(posedge wclk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // ------------------------------
    // Read port
    // ------------------------------

    // The addressed entry lands in rdata at the edge that samples re
    // It then holds until the next read strobe
    // A same-edge write to the same address is not forwarded, so the old entry is returned
    always_ff @(posedge rclk) begin
        if (!rd_rst_n) begin
            rdata <= '0;
        end else if (re) begin
            rdata <= mem[raddr];
        end
    end

    // ------------------------------
    // Assertions
    // ------------------------------

    // Write address must be known whenever the write strobe is up
    assert property (
        @(posedge wclk) disable iff (!rst_n)
        we |-> !$isunknown(waddr)
    ) else $error("list_sel_rf: unknown write address with we high");

    // Write address must select a real row
    assert property (
        @(posedge wclk) disable iff (!rst_n)
        we |-> (waddr < DEPTH)
    ) else $error("list_sel_rf: write address %0d out of range", waddr);

    // Read address must select a real row once the read side is out of reset
    assert property (
        @(posedge rclk) disable iff (!rd_rst_n)
        re |-> (raddr < DEPTH)
    ) else $error("list_sel_rf: read address %0d out of range", raddr);

endmodule
